// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
TOP        ?= tb_soc_top
DUT_TOP    ?= soc_top
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== common/soc_pkg.sv ====
// SoC package with the memory map, bus widths, bus types and target encoding

package soc_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned AddrWidth    = 64;
  localparam int unsigned DataWidth    = 64;
  localparam int unsigned StrbWidth    = DataWidth / 8;
  // UART side of the APB bridge
  localparam int unsigned ApbDataWidth = 32;

  typedef logic [AddrWidth-1:0]    bus_addr_t;
  typedef logic [DataWidth-1:0]    bus_data_t;
  typedef logic [StrbWidth-1:0]    bus_strb_t;
  typedef logic [ApbDataWidth-1:0] apb_data_t;

  ////////////////////////////////////////////////////////////////////////////
  // Memory map
  ////////////////////////////////////////////////////////////////////////////

  // 1 GiB DRAM window, served by the on-chip L2
  localparam bus_addr_t DramBase   = 64'h0000_0000_8000_0000;
  localparam bus_addr_t DramLength = 64'h0000_0000_4000_0000;

  localparam bus_addr_t UartBase   = 64'h0000_0000_C000_0000;
  localparam bus_addr_t UartLength = 64'h0000_0000_0000_1000;

  localparam bus_addr_t CtrlBase   = 64'h0000_0000_D000_0000;
  localparam bus_addr_t CtrlLength = 64'h0000_0000_0000_1000;

  // Control register offsets within the control region
  localparam bus_addr_t CtrlExitOffset     = 64'h00;
  localparam bus_addr_t CtrlHwCntOffset    = 64'h08;
  localparam bus_addr_t CtrlDramBaseOffset = 64'h10;
  localparam bus_addr_t CtrlDramEndOffset  = 64'h18;

  typedef enum logic [1:0] {
    TgtL2   = 2'd0,
    TgtUart = 2'd1,
    TgtCtrl = 2'd2,
    TgtNone = 2'd3
  } soc_target_e;

  // Replace the enabled bytes of a word
  function automatic bus_data_t be_merge(bus_data_t old_data, bus_data_t new_data,
                                         bus_strb_t be);
    bus_data_t res;
    res = old_data;
    for (int i = 0; i < StrbWidth; i++) begin
      if (be[i])
        res[8*i +: 8] = new_data[8*i +: 8];
    end
    return res;
  endfunction

endpackage : soc_pkg

// ==== dv/tb_tasks.svh ====
// Bus driver, compare tasks, random source and directed tests for the SoC testbench
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

function automatic logic [31:0] xorshift(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

// Expected word after a write with byte enables
function automatic bus_data_t apply_be(input bus_data_t old_word, input bus_data_t new_word,
                                       input bus_strb_t be);
  bus_data_t mask;
  for (int i = 0; i < 8; i++)
    mask[8*i +: 8] = {8{be[i]}};
  return (old_word & ~mask) | (new_word & mask);
endfunction

task automatic check_data(input string name, input bus_data_t got, input bus_data_t exp);
  if (got !== exp)
    stop_on_error($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
endtask

task automatic check_err(input string name, input logic got, input logic exp);
  if (got !== exp)
    stop_on_error($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
endtask

task automatic check_apb_word(input string name, input apb_data_t got, input apb_data_t exp);
  if (got !== exp)
    stop_on_error($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
endtask

// One request on the master port, returns the response
task automatic bus_access(input logic we, input bus_addr_t addr, input bus_data_t wdata,
                          input bus_strb_t be, output bus_data_t rdata, output logic err);
  @(negedge clk_i);
  while (!req_ready_o)
    @(negedge clk_i);
  req_valid_i = 1'b1;
  req_we_i    = we;
  req_addr_i  = addr;
  req_wdata_i = wdata;
  req_be_i    = be;
  @(negedge clk_i);
  req_valid_i = 1'b0;
  while (!rsp_valid_o)
    @(negedge clk_i);
  rdata = rsp_rdata_o;
  err   = rsp_err_o;
endtask

////////////////////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////////////////////

task automatic test_reset_state();
  check_err("req_ready_o", req_ready_o, 1'b1);
  check_err("rsp_valid_o", rsp_valid_o, 1'b0);
  check_err("uart_psel_o", uart_psel_o, 1'b0);
  check_err("uart_penable_o", uart_penable_o, 1'b0);
  check_data("exit_o", exit_o, '0);
  check_data("hw_cnt_en_o", hw_cnt_en_o, '0);
endtask

task automatic test_l2_merge();
  bus_data_t rd;
  bus_data_t exp;
  logic      err;
  exp = 64'h0123_4567_89AB_CDEF;
  bus_access(1'b1, DramBase + 64'h100, exp, 8'hFF, rd, err);
  check_err("l2 write err", err, 1'b0);
  bus_access(1'b1, DramBase + 64'h100, 64'hAAAA_AAAA_AAAA_AAAA, 8'h0F, rd, err);
  exp = apply_be(exp, 64'hAAAA_AAAA_AAAA_AAAA, 8'h0F);
  check_err("l2 write err", err, 1'b0);
  bus_access(1'b1, DramBase + 64'h100, 64'h5555_5555_5555_5555, 8'hA0, rd, err);
  exp = apply_be(exp, 64'h5555_5555_5555_5555, 8'hA0);
  check_err("l2 write err", err, 1'b0);
  bus_access(1'b0, DramBase + 64'h100, '0, '0, rd, err);
  check_data("l2 merged word", rd, exp);
  check_err("l2 read err", err, 1'b0);
endtask

task automatic test_l2_random();
  bus_data_t  rd;
  bus_data_t  wd;
  bus_addr_t  addr;
  bus_strb_t  be;
  logic [2:0] idx;
  logic       err;
  for (int i = 0; i < 8; i++) begin
    tb_rng      = xorshift(tb_rng);
    l2_model[i] = {tb_rng, ~tb_rng};
    bus_access(1'b1, DramBase + {58'd0, i[2:0], 3'b000}, l2_model[i], 8'hFF, rd, err);
    check_err("l2 fill err", err, 1'b0);
  end
  for (int n = 0; n < 40; n++) begin
    tb_rng = xorshift(tb_rng);
    idx    = tb_rng[2:0];
    be     = tb_rng[15:8];
    addr   = DramBase + {58'd0, idx, 3'b000};
    if (tb_rng[31]) begin
      wd = {xorshift(tb_rng), tb_rng};
      bus_access(1'b1, addr, wd, be, rd, err);
      l2_model[idx] = apply_be(l2_model[idx], wd, be);
    end else begin
      bus_access(1'b0, addr, '0, '0, rd, err);
      check_data("l2 random read", rd, l2_model[idx]);
    end
    check_err("l2 random err", err, 1'b0);
  end
endtask

task automatic test_ctrl_regs();
  bus_data_t rd;
  logic      err;
  bus_access(1'b1, CtrlBase + CtrlExitOffset, 64'h2A, 8'hFF, rd, err);
  check_err("exit write err", err, 1'b0);
  check_data("exit_o", exit_o, 64'h2A);
  bus_access(1'b0, CtrlBase + CtrlExitOffset, '0, '0, rd, err);
  check_data("exit readback", rd, 64'h2A);
  bus_access(1'b1, CtrlBase + CtrlHwCntOffset, '1, 8'h01, rd, err);
  check_err("hw_cnt write err", err, 1'b0);
  check_data("hw_cnt_en_o", hw_cnt_en_o, apply_be('0, '1, 8'h01));
  bus_access(1'b0, CtrlBase + CtrlHwCntOffset, '0, '0, rd, err);
  check_data("hw_cnt readback", rd, 64'hFF);
  // DRAM window twice, the writes in between must not stick
  for (int pass = 0; pass < 2; pass++) begin
    bus_access(1'b0, CtrlBase + CtrlDramBaseOffset, '0, '0, rd, err);
    check_data("dram base", rd, 64'h8000_0000);
    check_err("dram base err", err, 1'b0);
    bus_access(1'b0, CtrlBase + CtrlDramEndOffset, '0, '0, rd, err);
    check_data("dram end", rd, 64'hC000_0000);
    if (pass == 0) begin
      bus_access(1'b1, CtrlBase + CtrlDramBaseOffset, 64'hDEAD, 8'hFF, rd, err);
      check_err("dram base write err", err, 1'b0);
      bus_access(1'b1, CtrlBase + CtrlDramEndOffset, 64'hBEEF, 8'hFF, rd, err);
    end
  end
  bus_access(1'b0, CtrlBase + 64'h20, '0, '0, rd, err);
  check_err("ctrl bad offset err", err, 1'b1);
  check_data("ctrl bad offset data", rd, '0);
endtask

task automatic test_uart();
  bus_data_t rd;
  logic      err;
  bus_access(1'b1, UartBase + 64'h10, 64'hFFFF_0000_1234_5678, 8'hFF, rd, err);
  check_err("uart write err", err, 1'b0);
  check_apb_word("paddr", last_paddr, 32'hC000_0010);
  check_apb_word("pwdata", last_pwdata, 32'h1234_5678);
  check_err("pwrite", last_pwrite, 1'b1);
  bus_access(1'b0, UartBase + 64'h10, '0, '0, rd, err);
  check_err("pwrite", last_pwrite, 1'b0);
  check_data("uart read", rd, {32'h0, apb_image[4]});
  bus_access(1'b0, UartBase + 64'h20, '0, '0, rd, err);
  check_data("uart read", rd, {32'h0, apb_image[8]});
  check_err("uart read err", err, 1'b0);
  bus_access(1'b0, UartBase + 64'hFFC, '0, '0, rd, err);
  check_err("uart slave err", err, 1'b1);
endtask

task automatic test_unmapped();
  bus_data_t rd;
  logic      err;
  bus_access(1'b1, 64'h0, 64'h0BAD_0BAD_0BAD_0BAD, 8'hFF, rd, err);
  check_err("unmapped write err", err, 1'b1);
  check_data("unmapped write data", rd, '0);
  bus_access(1'b0, 64'h0, '0, '0, rd, err);
  check_err("unmapped read err", err, 1'b1);
  check_data("unmapped read data", rd, '0);
  bus_access(1'b1, 64'hE000_0000, 64'h0BAD_0BAD_0BAD_0BAD, 8'hFF, rd, err);
  check_err("unmapped write err", err, 1'b1);
  bus_access(1'b0, 64'hE000_0000, '0, '0, rd, err);
  check_err("unmapped read err", err, 1'b1);
  check_data("unmapped read data", rd, '0);
  // Both unmapped addresses share the word index of the DRAM base
  bus_access(1'b0, DramBase, '0, '0, rd, err);
  check_data("l2 word after unmapped", rd, l2_model[0]);
  check_err("l2 read err", err, 1'b0);
endtask

`endif

// ==== dv/tb_soc_top.sv ====
// Testbench for the SoC peripheral top level with an APB slave model on the UART pins
`timescale 1ns/10ps

module tb_soc_top;

  import soc_pkg::*;

  localparam int unsigned L2AddrBits  = 10;
  // Requests per test: reset 0, merge 4, random 8+40, ctrl 11, uart 4, unmapped 5
  localparam int unsigned NumRequests = 72;
  localparam int unsigned MaxCycles   = NumRequests * 20 + 200;
  localparam logic [31:0] Seed        = 32'd86324;

  logic        clk_i;
  logic        arst_n_i;
  logic        req_valid_i;
  logic        req_we_i;
  bus_addr_t   req_addr_i;
  bus_data_t   req_wdata_i;
  bus_strb_t   req_be_i;
  logic        req_ready_o;
  logic        rsp_valid_o;
  bus_data_t   rsp_rdata_o;
  logic        rsp_err_o;
  bus_data_t   exit_o;
  bus_data_t   hw_cnt_en_o;
  logic        uart_psel_o;
  logic        uart_penable_o;
  logic        uart_pwrite_o;
  logic [31:0] uart_paddr_o;
  apb_data_t   uart_pwdata_o;
  apb_data_t   uart_prdata_i;
  logic        uart_pready_i;
  logic        uart_pslverr_i;

  // APB slave state and the last transfer it saw
  apb_data_t   apb_image [1024];
  logic [31:0] last_paddr;
  apb_data_t   last_pwdata;
  logic        last_pwrite;
  logic [31:0] apb_rng;
  logic [31:0] tb_rng;

  // L2 reference words at the bottom of the DRAM window
  bus_data_t   l2_model [8];

  int unsigned cycle_count = 0;

  soc_top #(
    .L2AddrBits(L2AddrBits)
  ) u_dut (
    .clk_i         (clk_i         ),
    .arst_n_i      (arst_n_i      ),
    .req_valid_i   (req_valid_i   ),
    .req_we_i      (req_we_i      ),
    .req_addr_i    (req_addr_i    ),
    .req_wdata_i   (req_wdata_i   ),
    .req_be_i      (req_be_i      ),
    .req_ready_o   (req_ready_o   ),
    .rsp_valid_o   (rsp_valid_o   ),
    .rsp_rdata_o   (rsp_rdata_o   ),
    .rsp_err_o     (rsp_err_o     ),
    .exit_o        (exit_o        ),
    .hw_cnt_en_o   (hw_cnt_en_o   ),
    .uart_psel_o   (uart_psel_o   ),
    .uart_penable_o(uart_penable_o),
    .uart_pwrite_o (uart_pwrite_o ),
    .uart_paddr_o  (uart_paddr_o  ),
    .uart_pwdata_o (uart_pwdata_o ),
    .uart_prdata_i (uart_prdata_i ),
    .uart_pready_i (uart_pready_i ),
    .uart_pslverr_i(uart_pslverr_i)
  );

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "first error ends the run");
  endtask

  `include "tb_tasks.svh"

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count > MaxCycles + 8)
      stop_on_error($sformatf("timeout after %0d clock cycles", cycle_count));
  end

  ////////////////////////////////////////////////////////////////////////////
  // APB slave model
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int unsigned wait_left;
    uart_prdata_i  = '0;
    uart_pready_i  = 1'b0;
    uart_pslverr_i = 1'b0;
    apb_rng        = Seed;
    wait_left      = 0;
    for (int i = 0; i < 1024; i++)
      apb_image[i] = {16'hA5C3, 4'h0, i[9:0], 2'b00};
    forever begin
      @(negedge clk_i);
      if (!uart_psel_o) begin
        uart_pready_i  = 1'b0;
        uart_pslverr_i = 1'b0;
      end else if (!uart_penable_o) begin
        // Setup phase, pick 0 to 3 wait cycles
        apb_rng   = xorshift(apb_rng);
        wait_left = apb_rng % 4;
        uart_pready_i = 1'b0;
      end else if (wait_left != 0) begin
        wait_left--;
      end else begin
        uart_pready_i  = 1'b1;
        uart_pslverr_i = (uart_paddr_o[11:0] == 12'hFFC);
        last_paddr     = uart_paddr_o;
        last_pwrite    = uart_pwrite_o;
        last_pwdata    = uart_pwdata_o;
        if (uart_pwrite_o && !uart_pslverr_i)
          apb_image[uart_paddr_o[11:2]] = uart_pwdata_o;
        uart_prdata_i = uart_pwrite_o ? '0 : apb_image[uart_paddr_o[11:2]];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    arst_n_i    = 1'b0;
    req_valid_i = 1'b0;
    req_we_i    = 1'b0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    req_be_i    = '0;
    tb_rng      = Seed;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    test_reset_state();
    test_l2_merge();
    test_l2_random();
    test_ctrl_regs();
    test_uart();
    test_unmapped();

    $display("Done: no errors");
    $finish;
  end

endmodule : tb_soc_top

// ==== hdl/ctrl_regs.sv ====
// Control registers for exit code, counter enable and the read-only DRAM window
`timescale 1ns/10ps

module ctrl_regs (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               req_i,
  input  logic               we_i,
  input  soc_pkg::bus_addr_t addr_i,
  input  soc_pkg::bus_data_t wdata_i,
  input  soc_pkg::bus_strb_t be_i,
  output logic               done_o,
  output soc_pkg::bus_data_t rdata_o,
  output logic               err_o,
  output soc_pkg::bus_data_t exit_o,
  output soc_pkg::bus_data_t hw_cnt_en_o
);

  import soc_pkg::*;

  bus_addr_t off;
  bus_data_t rd_val;
  logic      rd_err;

  assign off = addr_i & (CtrlLength - 64'd1);

  // Register read mux
  always_comb begin
    rd_val = '0;
    rd_err = 1'b0;
    case (off)
      CtrlExitOffset:     rd_val = exit_o;
      CtrlHwCntOffset:    rd_val = hw_cnt_en_o;
      CtrlDramBaseOffset: rd_val = DramBase;
      CtrlDramEndOffset:  rd_val = DramBase + DramLength;
      default:            rd_err = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_o      <= '0;
      hw_cnt_en_o <= '0;
      done_o      <= 1'b0;
      err_o       <= 1'b0;
    end else begin
      done_o <= req_i;
      if (req_i) begin
        err_o <= rd_err;
        // DRAM base and end silently ignore writes
        if (we_i && off == CtrlExitOffset)
          exit_o <= be_merge(exit_o, wdata_i, be_i);
        if (we_i && off == CtrlHwCntOffset)
          hw_cnt_en_o <= be_merge(hw_cnt_en_o, wdata_i, be_i);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i)
      rdata_o <= rd_val;
  end

endmodule : ctrl_regs

// ==== hdl/l2_mem.sv ====
// On-chip L2 memory with byte enables and a one-cycle read response
`timescale 1ns/10ps

module l2_mem #(
  parameter int unsigned L2AddrBits = 10
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               req_i,
  input  logic               we_i,
  input  soc_pkg::bus_addr_t addr_i,
  input  soc_pkg::bus_data_t wdata_i,
  input  soc_pkg::bus_strb_t be_i,
  output logic               done_o,
  output soc_pkg::bus_data_t rdata_o
);

  import soc_pkg::*;

  // Byte offset inside one bus word
  localparam int unsigned OffBits  = $clog2(StrbWidth);
  localparam int unsigned NumWords = 2 ** L2AddrBits;

  bus_data_t               mem_q [NumWords];
  logic [L2AddrBits-1:0]   word_idx;

  // Upper address bits are dropped, so the DRAM window wraps onto the array
  assign word_idx = addr_i[OffBits +: L2AddrBits];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i)
        mem_q[word_idx] <= be_merge(mem_q[word_idx], wdata_i, be_i);
      else
        rdata_o <= mem_q[word_idx];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      done_o <= 1'b0;
    end else begin
      done_o <= req_i;
    end
  end

  // One request at a time, answered in the next cycle
  a_done_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_i |=> done_o && !req_i)
    else $error("L2 done missing or a new request one cycle after the request");

endmodule : l2_mem

// ==== hdl/soc_addr_router.sv ====
// Address router that takes master requests and steers each one to a single target
`timescale 1ns/10ps

module soc_addr_router (
  input  logic               clk_i,
  input  logic               arst_n_i,
  // Master port
  input  logic               req_valid_i,
  input  logic               req_we_i,
  input  soc_pkg::bus_addr_t req_addr_i,
  input  soc_pkg::bus_data_t req_wdata_i,
  input  soc_pkg::bus_strb_t req_be_i,
  output logic               req_ready_o,
  output logic               rsp_valid_o,
  output soc_pkg::bus_data_t rsp_rdata_o,
  output logic               rsp_err_o,
  // Request shared by all targets
  output logic               tgt_we_o,
  output soc_pkg::bus_addr_t tgt_addr_o,
  output soc_pkg::bus_data_t tgt_wdata_o,
  output soc_pkg::bus_strb_t tgt_be_o,
  // Per-target strobes and answers
  output logic               l2_req_o,
  input  logic               l2_done_i,
  input  soc_pkg::bus_data_t l2_rdata_i,
  output logic               uart_req_o,
  input  logic               uart_done_i,
  input  soc_pkg::bus_data_t uart_rdata_i,
  input  logic               uart_err_i,
  output logic               ctrl_req_o,
  input  logic               ctrl_done_i,
  input  soc_pkg::bus_data_t ctrl_rdata_i,
  input  logic               ctrl_err_i
);

  import soc_pkg::*;

  typedef enum logic [1:0] {
    StIdle,
    StBusy,
    StResp
  } state_e;

  state_e      state_q;
  soc_target_e tgt_dec;
  soc_target_e tgt_q;
  logic        accept;
  logic        fin;
  bus_data_t   fin_rdata;
  logic        fin_err;

  assign req_ready_o = (state_q == StIdle);
  assign accept      = req_valid_i && req_ready_o;

  // Region decode on the incoming address
  always_comb begin
    tgt_dec = TgtNone;
    if (req_addr_i >= DramBase && req_addr_i < DramBase + DramLength)
      tgt_dec = TgtL2;
    else if (req_addr_i >= UartBase && req_addr_i < UartBase + UartLength)
      tgt_dec = TgtUart;
    else if (req_addr_i >= CtrlBase && req_addr_i < CtrlBase + CtrlLength)
      tgt_dec = TgtCtrl;
  end

  // Answer of the target in flight; unmapped finishes at once
  always_comb begin
    fin       = 1'b0;
    fin_rdata = '0;
    fin_err   = 1'b0;
    case (tgt_q)
      TgtL2: begin
        fin       = l2_done_i;
        fin_rdata = l2_rdata_i;
      end
      TgtUart: begin
        fin       = uart_done_i;
        fin_rdata = uart_rdata_i;
        fin_err   = uart_err_i;
      end
      TgtCtrl: begin
        fin       = ctrl_done_i;
        fin_rdata = ctrl_rdata_i;
        fin_err   = ctrl_err_i;
      end
      default: begin
        fin     = 1'b1;
        fin_err = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= StIdle;
      tgt_q       <= TgtNone;
      l2_req_o    <= 1'b0;
      uart_req_o  <= 1'b0;
      ctrl_req_o  <= 1'b0;
      rsp_valid_o <= 1'b0;
    end else begin
      l2_req_o    <= accept && (tgt_dec == TgtL2);
      uart_req_o  <= accept && (tgt_dec == TgtUart);
      ctrl_req_o  <= accept && (tgt_dec == TgtCtrl);
      rsp_valid_o <= (state_q == StBusy) && fin;
      case (state_q)
        StIdle: begin
          if (accept) begin
            state_q <= StBusy;
            tgt_q   <= tgt_dec;
          end
        end
        StBusy: begin
          if (fin)
            state_q <= StResp;
        end
        default: state_q <= StIdle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      tgt_we_o    <= req_we_i;
      tgt_addr_o  <= req_addr_i;
      tgt_wdata_o <= req_wdata_i;
      tgt_be_o    <= req_be_i;
    end
    if (state_q == StBusy && fin) begin
      rsp_rdata_o <= fin_rdata;
      rsp_err_o   <= fin_err;
    end
  end

  // Only the strobed target may ever answer
  a_single_done: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0({l2_done_i, uart_done_i, ctrl_done_i}))
    else $error("More than one target done in the same cycle");

endmodule : soc_addr_router

// ==== hdl/soc_top.sv ====
// SoC peripheral top level joining the router, L2, UART bridge and control registers
`timescale 1ns/10ps

module soc_top #(
  parameter int unsigned L2AddrBits = 10
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  // Master port
  input  logic               req_valid_i,
  input  logic               req_we_i,
  input  soc_pkg::bus_addr_t req_addr_i,
  input  soc_pkg::bus_data_t req_wdata_i,
  input  soc_pkg::bus_strb_t req_be_i,
  output logic               req_ready_o,
  output logic               rsp_valid_o,
  output soc_pkg::bus_data_t rsp_rdata_o,
  output logic               rsp_err_o,
  output soc_pkg::bus_data_t exit_o,
  output soc_pkg::bus_data_t hw_cnt_en_o,
  // UART APB pins
  output logic               uart_psel_o,
  output logic               uart_penable_o,
  output logic               uart_pwrite_o,
  output logic [31:0]        uart_paddr_o,
  output soc_pkg::apb_data_t uart_pwdata_o,
  input  soc_pkg::apb_data_t uart_prdata_i,
  input  logic               uart_pready_i,
  input  logic               uart_pslverr_i
);

  import soc_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Router
  ////////////////////////////////////////////////////////////////////////////

  logic      tgt_we;
  bus_addr_t tgt_addr;
  bus_data_t tgt_wdata;
  bus_strb_t tgt_be;

  logic      l2_req;
  logic      l2_done;
  bus_data_t l2_rdata;
  logic      uart_req;
  logic      uart_done;
  bus_data_t uart_rdata;
  logic      uart_err;
  logic      ctrl_req;
  logic      ctrl_done;
  bus_data_t ctrl_rdata;
  logic      ctrl_err;

  soc_addr_router u_router (
    .clk_i       (clk_i      ),
    .arst_n_i    (arst_n_i   ),
    .req_valid_i (req_valid_i),
    .req_we_i    (req_we_i   ),
    .req_addr_i  (req_addr_i ),
    .req_wdata_i (req_wdata_i),
    .req_be_i    (req_be_i   ),
    .req_ready_o (req_ready_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_rdata_o (rsp_rdata_o),
    .rsp_err_o   (rsp_err_o  ),
    .tgt_we_o    (tgt_we     ),
    .tgt_addr_o  (tgt_addr   ),
    .tgt_wdata_o (tgt_wdata  ),
    .tgt_be_o    (tgt_be     ),
    .l2_req_o    (l2_req     ),
    .l2_done_i   (l2_done    ),
    .l2_rdata_i  (l2_rdata   ),
    .uart_req_o  (uart_req   ),
    .uart_done_i (uart_done  ),
    .uart_rdata_i(uart_rdata ),
    .uart_err_i  (uart_err   ),
    .ctrl_req_o  (ctrl_req   ),
    .ctrl_done_i (ctrl_done  ),
    .ctrl_rdata_i(ctrl_rdata ),
    .ctrl_err_i  (ctrl_err   )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Targets
  ////////////////////////////////////////////////////////////////////////////

  l2_mem #(
    .L2AddrBits(L2AddrBits)
  ) u_l2_mem (
    .clk_i   (clk_i    ),
    .arst_n_i(arst_n_i ),
    .req_i   (l2_req   ),
    .we_i    (tgt_we   ),
    .addr_i  (tgt_addr ),
    .wdata_i (tgt_wdata),
    .be_i    (tgt_be   ),
    .done_o  (l2_done  ),
    .rdata_o (l2_rdata )
  );

  uart_apb_bridge u_uart_bridge (
    .clk_i         (clk_i         ),
    .arst_n_i      (arst_n_i      ),
    .req_i         (uart_req      ),
    .we_i          (tgt_we        ),
    .addr_i        (tgt_addr      ),
    .wdata_i       (tgt_wdata     ),
    .done_o        (uart_done     ),
    .rdata_o       (uart_rdata    ),
    .err_o         (uart_err      ),
    .uart_psel_o   (uart_psel_o   ),
    .uart_penable_o(uart_penable_o),
    .uart_pwrite_o (uart_pwrite_o ),
    .uart_paddr_o  (uart_paddr_o  ),
    .uart_pwdata_o (uart_pwdata_o ),
    .uart_prdata_i (uart_prdata_i ),
    .uart_pready_i (uart_pready_i ),
    .uart_pslverr_i(uart_pslverr_i)
  );

  ctrl_regs u_ctrl_regs (
    .clk_i      (clk_i      ),
    .arst_n_i   (arst_n_i   ),
    .req_i      (ctrl_req   ),
    .we_i       (tgt_we     ),
    .addr_i     (tgt_addr   ),
    .wdata_i    (tgt_wdata  ),
    .be_i       (tgt_be     ),
    .done_o     (ctrl_done  ),
    .rdata_o    (ctrl_rdata ),
    .err_o      (ctrl_err   ),
    .exit_o     (exit_o     ),
    .hw_cnt_en_o(hw_cnt_en_o)
  );

endmodule : soc_top

// ==== uart_apb/uart_apb_bridge.sv ====
// Bridge from a single bus request to an APB setup/access transfer on the UART
`timescale 1ns/10ps

module uart_apb_bridge (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               req_i,
  input  logic               we_i,
  input  soc_pkg::bus_addr_t addr_i,
  input  soc_pkg::bus_data_t wdata_i,
  output logic               done_o,
  output soc_pkg::bus_data_t rdata_o,
  output logic               err_o,
  // APB master to the UART
  output logic               uart_psel_o,
  output logic               uart_penable_o,
  output logic               uart_pwrite_o,
  output logic [31:0]        uart_paddr_o,
  output soc_pkg::apb_data_t uart_pwdata_o,
  input  soc_pkg::apb_data_t uart_prdata_i,
  input  logic               uart_pready_i,
  input  logic               uart_pslverr_i
);

  import soc_pkg::*;

  typedef enum logic [1:0] {
    ApbIdle,
    ApbSetup,
    ApbAccess
  } apb_state_e;

  apb_state_e state_q;

  assign uart_psel_o    = (state_q != ApbIdle);
  assign uart_penable_o = (state_q == ApbAccess);

  // Transfer ends on the edge that sees pready
  assign done_o  = uart_penable_o && uart_pready_i;
  assign rdata_o = {{(DataWidth - ApbDataWidth){1'b0}}, uart_prdata_i};
  assign err_o   = uart_penable_o && uart_pslverr_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ApbIdle;
    end else begin
      case (state_q)
        ApbIdle: begin
          if (req_i)
            state_q <= ApbSetup;
        end
        ApbSetup: state_q <= ApbAccess;
        ApbAccess: begin
          if (uart_pready_i)
            state_q <= ApbIdle;
        end
        default: state_q <= ApbIdle;
      endcase
    end
  end

  // Low halves only; the UART is a 32-bit slave
  always_ff @(posedge clk_i) begin
    if (req_i && state_q == ApbIdle) begin
      uart_pwrite_o <= we_i;
      uart_paddr_o  <= addr_i[31:0];
      uart_pwdata_o <= wdata_i[ApbDataWidth-1:0];
    end
  end

  // Access lies inside a select, and no new request arrives during it
  a_apb_access: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    uart_penable_o |-> uart_psel_o && !req_i)
    else $error("APB access phase without select or with a new request");

endmodule : uart_apb_bridge

// ==== verilog.f ====
+incdir+dv
common/soc_pkg.sv
hdl/soc_addr_router.sv
hdl/l2_mem.sv
uart_apb/uart_apb_bridge.sv
hdl/ctrl_regs.sv
hdl/soc_top.sv
dv/tb_soc_top.sv
